/* Makefile */
TOP := tb_tti_tx
OBJ := obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
	  --top-module $(TOP) -Mdir $(OBJ) -f files.f

run: compile
	./$(OBJ)/V$(TOP) | tee sim.log
	@! grep -q "Test FAILED" sim.log
	@grep -q "Test OK" sim.log

clean:
	rm -rf $(OBJ) sim.log

/* files.f */
hdl/tti_tx_pkg.sv
hdl/tti_tx_fifo.sv
hdl/tx_word_to_byte.sv
hdl/descriptor_tx.sv
hdl/target_read_responder.sv
hdl/tti_tx_top.sv
tests/tb_tti_tx.sv

/* hdl/descriptor_tx.sv */
// TX descriptor handler; starts a message once its data is queued and flags the last byte
module descriptor_tx
  import tti_tx_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     rst_ni,

  // Descriptor queue read side
  input  logic                     desc_valid_i,
  output logic                     desc_ready_o,
  input  logic [TtiDescWidth-1:0]  desc_i,

  // Occupancy of the data queue
  input  logic [TtiDepthWidth-1:0] data_depth_i,

  // Bytes from the converter
  input  logic                     byte_valid_i,
  output logic                     byte_ready_o,
  input  logic [TtiByteWidth-1:0]  byte_i,

  // Toward the read responder
  output logic [TtiByteWidth-1:0]  tx_byte_o,
  output logic                     tx_byte_valid_o,
  output logic                     tx_byte_last_o,
  input  logic                     tx_byte_ready_i,
  input  logic                     tx_abort_i,
  output logic                     tx_flush_o
);

  localparam int unsigned LenWidth = DescLenMsb - DescLenLsb + 1;

  logic [TtiDescWidth-1:0] desc_q;
  logic                    desc_held_q;
  logic                    pending_q;
  logic [LenWidth-1:0]     count_q;
  logic [LenWidth-1:0]     data_len;
  logic [LenWidth-1:0]     data_len_words;
  logic [TtiDepthWidth:0]  words_avail;
  logic                    capture;
  logic                    tx_start;
  logic                    tx_accept;
  logic                    tx_end;
  logic                    release_desc;

  // One descriptor at a time
  assign desc_ready_o = !desc_held_q;
  assign capture      = desc_valid_i && desc_ready_o;

  assign data_len       = desc_q[DescLenMsb:DescLenLsb];
  assign data_len_words = data_len >> 2;

  // The converter may already hold one word of this message
  assign words_avail = {1'b0, data_depth_i} + 1'b1;
  assign tx_start    = desc_held_q && !pending_q &&
                       (words_avail >= (TtiDepthWidth + 1)'(data_len_words));

  assign tx_byte_o       = byte_i;
  assign tx_byte_valid_o = pending_q && byte_valid_i;
  assign tx_byte_last_o  = (count_q == LenWidth'(1));
  assign byte_ready_o    = pending_q && tx_byte_ready_i;

  assign tx_accept    = tx_byte_valid_o && tx_byte_ready_i;
  assign tx_end       = tx_accept && tx_byte_last_o;
  assign release_desc = tx_end || tx_abort_i;

  // Remaining bytes and the converter go with the message
  assign tx_flush_o = release_desc;

  always_ff @(posedge clk_i) begin
    if (capture) desc_q <= desc_i;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      desc_held_q <= 1'b0;
    end else if (desc_held_q && release_desc) begin
      desc_held_q <= 1'b0;
    end else if (capture) begin
      desc_held_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q <= 1'b0;
    end else if (release_desc) begin
      pending_q <= 1'b0;
    end else if (tx_start) begin
      pending_q <= 1'b1;
    end
  end

  // Counts down the bytes still owed on the bus
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q <= '0;
    end else if (tx_abort_i) begin
      count_q <= '0;
    end else if (tx_start) begin
      count_q <= data_len;
    end else if (tx_accept) begin
      count_q <= count_q - 1'b1;
    end
  end

  // Only whole words per message
  a_desc_len_words: assert property (@(posedge clk_i) disable iff (!rst_ni)
    capture |=> (data_len != '0) && (data_len[1:0] == 2'b00))
    else $error("descriptor_tx: length is zero or not a multiple of 4");

endmodule

/* hdl/target_read_responder.sv */
// Private-read responder FSM; ACKs or NACKs reads and drives message bytes on the bus port
module target_read_responder
  import tti_tx_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_ni,

  // Bus events
  input  logic                    read_req_i,
  input  logic                    bus_stop_i,
  input  logic                    bus_err_i,

  // Byte-level bus port
  input  logic                    bus_ready_i,
  output logic [TtiByteWidth-1:0] bus_byte_o,
  output logic                    bus_valid_o,
  output logic                    bus_tbit_o,
  output logic                    read_ack_o,
  output logic                    read_nack_o,

  // From the descriptor handler
  input  logic [TtiByteWidth-1:0] tx_byte_i,
  input  logic                    tx_byte_valid_i,
  input  logic                    tx_byte_last_i,
  output logic                    tx_byte_ready_o,
  output logic                    tx_abort_o
);

  tgt_state_e state_q;
  tgt_state_e state_d;
  logic       in_send;

  assign in_send = (state_q == TgtSend);

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      TgtIdle: begin
        // A message must be ready at the request to ACK
        if (read_req_i) state_d = tx_byte_valid_i ? TgtAck : TgtNack;
      end
      TgtAck:  state_d = TgtSend;
      TgtSend: begin
        if (bus_valid_o && bus_ready_i && tx_byte_last_i) state_d = TgtIdle;
      end
      TgtNack:  state_d = TgtIdle;
      TgtAbort: state_d = TgtIdle;
      default:  state_d = TgtIdle;
    endcase
    // Stop or error wins in every state
    if (bus_stop_i || bus_err_i) state_d = TgtAbort;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= TgtIdle;
    end else begin
      state_q <= state_d;
    end
  end

  assign read_ack_o  = (state_q == TgtAck);
  assign read_nack_o = (state_q == TgtNack);
  assign tx_abort_o  = (state_q == TgtAbort);

  // Bytes pass through only while sending
  assign bus_byte_o      = tx_byte_i;
  assign bus_valid_o     = in_send && tx_byte_valid_i;
  assign bus_tbit_o      = bus_valid_o && tx_byte_last_i;
  assign tx_byte_ready_o = in_send && bus_ready_i;

  // An ACKed read offers its first byte right away
  a_ack_then_byte: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (read_ack_o && !bus_stop_i && !bus_err_i) |=> bus_valid_o)
    else $error("target_read_responder: ACKed read has no byte to send");

  // Back-pressure keeps the upstream byte steady
  a_byte_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (bus_valid_o && !bus_ready_i && !bus_stop_i && !bus_err_i)
      |=> bus_valid_o && $stable(bus_byte_o) && $stable(bus_tbit_o))
    else $error("target_read_responder: byte changed while stalled");

endmodule

/* hdl/tti_tx_fifo.sv */
// Synchronous FIFO with occupancy count and flush, instanced for TX descriptors and TX data
module tti_tx_fifo
  import tti_tx_pkg::*;
#(
  parameter int unsigned Width = 32,
  parameter int unsigned Depth = 4
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     flush_i,
  input  logic                     wvalid_i,
  output logic                     wready_o,
  input  logic [Width-1:0]         wdata_i,
  output logic                     rvalid_o,
  input  logic                     rready_i,
  output logic [Width-1:0]         rdata_o,
  output logic [TtiDepthWidth-1:0] depth_o
);

  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam logic [TtiDepthWidth-1:0] DepthMax = TtiDepthWidth'(Depth);
  localparam logic [PtrWidth-1:0] PtrLast = PtrWidth'(Depth - 1);

  logic [Width-1:0]         mem_q [Depth];
  logic [PtrWidth-1:0]      wptr_q;
  logic [PtrWidth-1:0]      rptr_q;
  logic [TtiDepthWidth-1:0] count_q;
  logic                     push;
  logic                     pop;

  assign wready_o = (count_q != DepthMax);
  assign rvalid_o = (count_q != '0);
  assign rdata_o  = mem_q[rptr_q];
  assign depth_o  = count_q;
  assign push     = wvalid_i && wready_o;
  assign pop      = rvalid_o && rready_i;

  always_ff @(posedge clk_i) begin
    if (push) mem_q[wptr_q] <= wdata_i;
  end

  // Pointers wrap at the last entry, so any depth works
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else if (flush_i) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else begin
      if (push) wptr_q <= (wptr_q == PtrLast) ? '0 : wptr_q + 1'b1;
      if (pop) rptr_q <= (rptr_q == PtrLast) ? '0 : rptr_q + 1'b1;
      if (push && !pop) count_q <= count_q + 1'b1;
      else if (pop && !push) count_q <= count_q - 1'b1;
    end
  end

  // Occupancy never passes the depth
  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
    count_q <= DepthMax)
    else $error("tti_tx_fifo: occupancy above the queue depth");

  // Read pointer plus occupancy lands on the write pointer
  a_ptrs_match_count: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ((32'(rptr_q) + 32'(count_q)) % Depth) == 32'(wptr_q))
    else $error("tti_tx_fifo: pointers and occupancy disagree");

endmodule

/* hdl/tti_tx_pkg.sv */
// Shared widths, descriptor fields and responder states for the TTI transmit path
package tti_tx_pkg;

  // Host-side word widths
  parameter int unsigned TtiDescWidth = 32;
  parameter int unsigned TtiDataWidth = 32;

  // One bus transfer
  parameter int unsigned TtiByteWidth = 8;

  // Queue occupancy count
  parameter int unsigned TtiDepthWidth = 16;

  // Byte length field inside a TX descriptor
  parameter int unsigned DescLenLsb = 0;
  parameter int unsigned DescLenMsb = 15;

  // Private-read responder states
  typedef enum logic [2:0] {
    TgtIdle,
    TgtAck,
    TgtSend,
    TgtNack,
    TgtAbort
  } tgt_state_e;

endpackage

/* hdl/tti_tx_top.sv */
// Top level of the TTI transmit path; host queues feed the converter, handler and responder
module tti_tx_top
  import tti_tx_pkg::*;
#(
  parameter int unsigned DescQueueDepth = 4,
  parameter int unsigned DataQueueDepth = 16
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,

  // Host side
  input  logic                    desc_valid_i,
  output logic                    desc_ready_o,
  input  logic [TtiDescWidth-1:0] desc_data_i,
  input  logic                    data_valid_i,
  output logic                    data_ready_o,
  input  logic [TtiDataWidth-1:0] data_word_i,

  // Bus side
  input  logic                    read_req_i,
  input  logic                    bus_ready_i,
  input  logic                    bus_stop_i,
  input  logic                    bus_err_i,
  output logic [TtiByteWidth-1:0] bus_byte_o,
  output logic                    bus_valid_o,
  output logic                    bus_tbit_o,
  output logic                    read_ack_o,
  output logic                    read_nack_o
);

  logic                     desc_rvalid;
  logic                     desc_rready;
  logic [TtiDescWidth-1:0]  desc_rdata;
  logic                     data_rvalid;
  logic                     data_rready;
  logic [TtiDataWidth-1:0]  data_rdata;
  logic [TtiDepthWidth-1:0] data_depth;
  logic                     byte_valid;
  logic                     byte_ready;
  logic [TtiByteWidth-1:0]  byte_data;
  logic [TtiByteWidth-1:0]  tx_byte;
  logic                     tx_byte_valid;
  logic                     tx_byte_last;
  logic                     tx_byte_ready;
  logic                     tx_abort;
  logic                     tx_flush;

  tti_tx_fifo #(
    .Width(TtiDescWidth),
    .Depth(DescQueueDepth)
  ) i_desc_queue (
    .clk_i,
    .rst_ni,
    .flush_i (1'b0),
    .wvalid_i(desc_valid_i),
    .wready_o(desc_ready_o),
    .wdata_i (desc_data_i),
    .rvalid_o(desc_rvalid),
    .rready_i(desc_rready),
    .rdata_o (desc_rdata),
    .depth_o ()
  );

  tti_tx_fifo #(
    .Width(TtiDataWidth),
    .Depth(DataQueueDepth)
  ) i_data_queue (
    .clk_i,
    .rst_ni,
    .flush_i (tx_flush),
    .wvalid_i(data_valid_i),
    .wready_o(data_ready_o),
    .wdata_i (data_word_i),
    .rvalid_o(data_rvalid),
    .rready_i(data_rready),
    .rdata_o (data_rdata),
    .depth_o (data_depth)
  );

  tx_word_to_byte i_word_to_byte (
    .clk_i,
    .rst_ni,
    .flush_i     (tx_flush),
    .word_valid_i(data_rvalid),
    .word_ready_o(data_rready),
    .word_i      (data_rdata),
    .byte_valid_o(byte_valid),
    .byte_ready_i(byte_ready),
    .byte_o      (byte_data)
  );

  descriptor_tx i_descriptor_tx (
    .clk_i,
    .rst_ni,
    .desc_valid_i   (desc_rvalid),
    .desc_ready_o   (desc_rready),
    .desc_i         (desc_rdata),
    .data_depth_i   (data_depth),
    .byte_valid_i   (byte_valid),
    .byte_ready_o   (byte_ready),
    .byte_i         (byte_data),
    .tx_byte_o      (tx_byte),
    .tx_byte_valid_o(tx_byte_valid),
    .tx_byte_last_o (tx_byte_last),
    .tx_byte_ready_i(tx_byte_ready),
    .tx_abort_i     (tx_abort),
    .tx_flush_o     (tx_flush)
  );

  target_read_responder i_read_responder (
    .clk_i,
    .rst_ni,
    .read_req_i,
    .bus_stop_i,
    .bus_err_i,
    .bus_ready_i,
    .bus_byte_o,
    .bus_valid_o,
    .bus_tbit_o,
    .read_ack_o,
    .read_nack_o,
    .tx_byte_i      (tx_byte),
    .tx_byte_valid_i(tx_byte_valid),
    .tx_byte_last_i (tx_byte_last),
    .tx_byte_ready_o(tx_byte_ready),
    .tx_abort_o     (tx_abort)
  );

endmodule

/* hdl/tx_word_to_byte.sv */
// Word-to-byte converter between the TX data queue and the descriptor handler
module tx_word_to_byte
  import tti_tx_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    flush_i,
  input  logic                    word_valid_i,
  output logic                    word_ready_o,
  input  logic [TtiDataWidth-1:0] word_i,
  output logic                    byte_valid_o,
  input  logic                    byte_ready_i,
  output logic [TtiByteWidth-1:0] byte_o
);

  localparam int unsigned BytesPerWord = TtiDataWidth / TtiByteWidth;
  localparam logic [1:0] LastIdx = 2'(BytesPerWord - 1);

  logic [TtiDataWidth-1:0] word_q;
  logic [1:0]              idx_q;
  logic                    full_q;
  logic                    load;
  logic                    advance;

  // Takes a new word only once the held one is used up
  assign word_ready_o = !full_q;
  assign load         = word_valid_i && word_ready_o;

  assign byte_valid_o = full_q;
  assign advance      = byte_valid_o && byte_ready_i;

  // Least significant byte goes out first
  assign byte_o = word_q[idx_q*TtiByteWidth +: TtiByteWidth];

  always_ff @(posedge clk_i) begin
    if (load) word_q <= word_i;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      full_q <= 1'b0;
      idx_q  <= '0;
    end else if (flush_i) begin
      full_q <= 1'b0;
      idx_q  <= '0;
    end else if (load) begin
      full_q <= 1'b1;
      idx_q  <= '0;
    end else if (advance) begin
      idx_q <= idx_q + 1'b1;
      // Fourth byte gone, slot is free again
      if (idx_q == LastIdx) full_q <= 1'b0;
    end
  end

endmodule

/* tests/tb_tti_tx.sv */
// Testbench for the TTI transmit path; replays tests/tti_tx_trace.txt and checks the bus bytes
module tb_tti_tx
  import tti_tx_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  logic                    clk_i;
  logic                    rst_ni;
  logic                    desc_valid_i;
  logic                    desc_ready_o;
  logic [TtiDescWidth-1:0] desc_data_i;
  logic                    data_valid_i;
  logic                    data_ready_o;
  logic [TtiDataWidth-1:0] data_word_i;
  logic                    read_req_i;
  logic                    bus_ready_i;
  logic                    bus_stop_i;
  logic                    bus_err_i;
  logic [TtiByteWidth-1:0] bus_byte_o;
  logic                    bus_valid_o;
  logic                    bus_tbit_o;
  logic                    read_ack_o;
  logic                    read_nack_o;

  int          errors;
  int          test_errors;
  int          tests_passed;
  int          tests_failed;
  int          cycle_count;
  int          cycle_limit;
  logic [31:0] lcg_state;
  logic        stall_on;
  logic [7:0]  stall_pat;
  logic [2:0]  stall_idx;
  int          abort_after;
  logic        abort_stop;
  logic [7:0]  exp_bytes[$];
  string       lines[$];

  tti_tx_top i_tti_tx_top (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("FAIL at %0d ns: %s expected %0h, got %0h", $time, name, expected, actual);
      errors++;
      test_errors++;
    end
  endtask

  task automatic bad_line(input int line_no);
    $display("Trace line %0d is malformed or has an unknown command", line_no);
    errors++;
    test_errors++;
  endtask

  // Trace mask if one is set, random otherwise
  task automatic drive_bus_ready();
    if (stall_on) begin
      bus_ready_i = stall_pat[stall_idx];
      stall_idx   = stall_idx + 3'd1;
    end else begin
      lcg_state   = lcg_next(lcg_state);
      bus_ready_i = lcg_state[16];
    end
  endtask

  task automatic write_desc(input logic [31:0] value);
    @(posedge clk_i);
    #1;
    desc_valid_i = 1'b1;
    desc_data_i  = value;
    @(negedge clk_i);
    while (!desc_ready_o) @(negedge clk_i);
    @(posedge clk_i);
    #1;
    desc_valid_i = 1'b0;
  endtask

  task automatic write_data(input logic [31:0] value);
    @(posedge clk_i);
    #1;
    data_valid_i = 1'b1;
    data_word_i  = value;
    @(negedge clk_i);
    while (!data_ready_o) @(negedge clk_i);
    @(posedge clk_i);
    #1;
    data_valid_i = 1'b0;
  endtask

  task automatic run_read(input logic expect_ack);
    int   total;
    int   idx;
    logic acked;
    logic aborted;
    logic done;
    total   = exp_bytes.size();
    idx     = 0;
    aborted = 1'b0;
    done    = (total == 0);
    // Host writes take a couple of cycles to reach the handler
    repeat (2) @(posedge clk_i);
    #1;
    read_req_i = 1'b1;
    @(posedge clk_i);
    #1;
    read_req_i = 1'b0;
    @(negedge clk_i);
    acked = read_ack_o;
    check_value("read_ack_o", 32'(expect_ack), 32'(read_ack_o));
    check_value("read_nack_o", 32'(!expect_ack), 32'(read_nack_o));
    check_value("bus_valid_o", 32'd0, 32'(bus_valid_o));
    while (acked && !done) begin
      @(posedge clk_i);
      #1;
      if (idx == abort_after) begin
        bus_ready_i = 1'b0;
        bus_stop_i  = abort_stop;
        bus_err_i   = !abort_stop;
        @(posedge clk_i);
        #1;
        bus_stop_i = 1'b0;
        bus_err_i  = 1'b0;
        // Abort cycle and the return to idle carry no bytes
        repeat (3) begin
          @(negedge clk_i);
          check_value("bus_valid_o", 32'd0, 32'(bus_valid_o));
        end
        aborted = 1'b1;
        done    = 1'b1;
      end else begin
        drive_bus_ready();
        @(negedge clk_i);
        if (bus_valid_o && bus_ready_i) begin
          check_value("bus_byte_o", 32'(exp_bytes[idx]), 32'(bus_byte_o));
          check_value("bus_tbit_o", 32'(idx == total - 1), 32'(bus_tbit_o));
          idx++;
          if (bus_tbit_o || idx == total) done = 1'b1;
        end
      end
    end
    if (acked && !aborted) begin
      if (idx != total) begin
        $display("Read at %0d ns ended after %0d of %0d bytes", $time, idx, total);
        errors++;
        test_errors++;
      end
      @(negedge clk_i);
      check_value("bus_valid_o", 32'd0, 32'(bus_valid_o));
    end
    exp_bytes.delete();
    abort_after = -1;
  endtask

  task automatic finish_test(input string name);
    if (test_errors == 0) begin
      tests_passed++;
      $display("%s passed", name);
    end else begin
      tests_failed++;
      $display("%s failed with %0d mismatches", name, test_errors);
    end
    test_errors = 0;
    stall_on    = 1'b0;
  endtask

  task automatic run_line(input string line, input int line_no);
    string       cmd;
    string       arg;
    logic [31:0] word;
    logic [7:0]  b0;
    logic [7:0]  b1;
    logic [7:0]  b2;
    logic [7:0]  b3;
    int          n;
    int          count;
    n = $sscanf(line, "%s", cmd);
    if (n == 1 && cmd.getc(0) != "#") begin
      if (cmd == "DESC" || cmd == "DATA" || cmd == "STALL") begin
        n = $sscanf(line, "%s %h", cmd, word);
        if (n != 2) bad_line(line_no);
        else if (cmd == "DESC") write_desc(word);
        else if (cmd == "DATA") write_data(word);
        else begin
          stall_on  = 1'b1;
          stall_pat = word[7:0];
          stall_idx = 3'd0;
        end
      end else if (cmd == "EXP") begin
        n = $sscanf(line, "%s %h %h %h %h", cmd, b0, b1, b2, b3);
        if (n == 5) begin
          exp_bytes.push_back(b0);
          exp_bytes.push_back(b1);
          exp_bytes.push_back(b2);
          exp_bytes.push_back(b3);
        end else begin
          bad_line(line_no);
        end
      end else if (cmd == "STOP" || cmd == "ERR") begin
        n = $sscanf(line, "%s %d", cmd, count);
        abort_after = count;
        abort_stop  = (cmd == "STOP");
        if (n != 2) bad_line(line_no);
      end else if (cmd == "READ") begin
        n = $sscanf(line, "%s %s", cmd, arg);
        if (n == 2 && (arg == "ACK" || arg == "NACK")) run_read(arg == "ACK");
        else bad_line(line_no);
      end else if (cmd == "END") begin
        n = $sscanf(line, "%s %s", cmd, arg);
        finish_test((n == 2) ? arg : "unnamed");
      end else begin
        bad_line(line_no);
      end
    end
  endtask

  initial begin
    int    fd;
    string line;
    errors       = 0;
    test_errors  = 0;
    tests_passed = 0;
    tests_failed = 0;
    lcg_state    = 32'd16435;
    stall_on     = 1'b0;
    stall_pat    = 8'hff;
    stall_idx    = 3'd0;
    abort_after  = -1;
    abort_stop   = 1'b0;
    rst_ni       = 1'b0;
    desc_valid_i = 1'b0;
    desc_data_i  = '0;
    data_valid_i = 1'b0;
    data_word_i  = '0;
    read_req_i   = 1'b0;
    bus_ready_i  = 1'b0;
    bus_stop_i   = 1'b0;
    bus_err_i    = 1'b0;
    fd = $fopen("tests/tti_tx_trace.txt", "r");
    if (fd == 0) begin
      $display("Could not open the trace file");
      errors++;
    end else begin
      while (!$feof(fd)) begin
        if ($fgets(line, fd) != 0) lines.push_back(line);
      end
      $fclose(fd);
    end
    cycle_limit = lines.size() * 200;
    repeat (5) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    @(negedge clk_i);
    // Empty queues accept, bus side idle
    check_value("desc_ready_o", 32'd1, 32'(desc_ready_o));
    check_value("data_ready_o", 32'd1, 32'(data_ready_o));
    check_value("bus_valid_o", 32'd0, 32'(bus_valid_o));
    check_value("bus_tbit_o", 32'd0, 32'(bus_tbit_o));
    check_value("read_ack_o", 32'd0, 32'(read_ack_o));
    check_value("read_nack_o", 32'd0, 32'(read_nack_o));
    test_errors = 0;
    foreach (lines[i]) run_line(lines[i], i + 1);
    $display("%0d tests: %0d passed, %0d failed, %0d errors in total",
             tests_passed + tests_failed, tests_passed, tests_failed, errors);
    if (errors == 0 && tests_failed == 0 && tests_passed > 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  // Limit scales with the trace length
  initial begin
    cycle_count = 0;
    wait (cycle_limit != 0);
    while (cycle_count < cycle_limit) begin
      @(posedge clk_i);
      cycle_count++;
    end
    $display("Run timed out after %0d cycles", cycle_count);
    $display("Test FAILED");
    $finish;
  end

endmodule

/* tests/tti_tx_trace.txt */
# DESC length-hex | DATA word-hex | EXP four bytes-hex | STALL ready mask-hex, bit 0 first
# READ ACK or NACK | STOP or ERR bytes before the pulse | END test name
READ NACK
END nack_empty
DESC 00000004
DATA 44332211
EXP 11 22 33 44
STALL ff
READ ACK
END msg_4byte
DESC 0000000c
DATA 03020100
DATA 07060504
DATA 0b0a0908
EXP 00 01 02 03
EXP 04 05 06 07
EXP 08 09 0a 0b
STALL ff
READ ACK
END msg_12byte
DESC 0000000c
DATA a3a2a1a0
DATA b3b2b1b0
STALL ff
READ NACK
DATA c3c2c1c0
EXP a0 a1 a2 a3
EXP b0 b1 b2 b3
EXP c0 c1 c2 c3
READ ACK
END late_data
DESC 00000010
DATA 1a2b3c4d
DATA 5e6f7081
DATA deadbeef
DATA 01234567
EXP 4d 3c 2b 1a
EXP 81 70 6f 5e
EXP ef be ad de
EXP 67 45 23 01
READ ACK
END random_stall
DATA 55aa33cc
DATA 0f1e2d3c
DESC 00000008
EXP cc 33 aa 55
EXP 3c 2d 1e 0f
STALL 35
READ ACK
END pattern_stall
DESC 0000000c
DATA 13121110
DATA 17161514
DATA 1b1a1918
EXP 10 11 12 13
EXP 14 15 16 17
EXP 18 19 1a 1b
STALL ff
STOP 5
READ ACK
READ NACK
DATA 63626160
DATA 67666564
DESC 00000008
EXP 60 61 62 63
EXP 64 65 66 67
READ ACK
END stop_flush
DATA 73727170
DATA 77767574
DESC 00000008
EXP 70 71 72 73
EXP 74 75 76 77
ERR 2
READ ACK
READ NACK
DATA 8b8a8988
DESC 00000004
EXP 88 89 8a 8b
READ ACK
END err_flush
